// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_nettlp_rx_capture
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not the exit code of the simulation
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+verilog
verilog/nettlp_pkg.sv
verilog/tlp_header_decode.sv
verilog/capture_timer.sv
verilog/tlp_capture_fsm.sv
verilog/beat_fifo.sv
verilog/capture_regs.sv
verilog/nettlp_rx_capture.sv
testbench/tb_nettlp_rx_capture.sv

// File: testbench/tb_nettlp_rx_capture.sv
`timescale 1ns/1ps
`include "nettlp_config.svh"

module tb_nettlp_rx_capture;
	import nettlp_pkg::*;

	localparam int AXIL_TIMEOUT = 50;
	localparam int POP_TIMEOUT  = 200;

	logic           pcie_clk;
	logic           pcie_rst;
	logic           pcie_tready;
	rx_beat_t       rx;
	capture_entry_t out_entry;
	logic           out_valid;
	logic           out_ready;
	axil_req_t      axil_req;
	axil_rsp_t      axil_rsp;

	rx_beat_t       tx_beats[$];
	capture_entry_t exp_entries[$];
	count_t         exp_tlp;
	count_t         exp_drop;
	count_t         exp_tmo;
	count_t         exp_ovf;
	int             checks;
	int             mismatches;
	int             failures;

	nettlp_rx_capture nettlp_rx_capture_i (
		.pcie_clk   (pcie_clk),
		.pcie_rst   (pcie_rst),
		.pcie_tready(pcie_tready),
		.rx         (rx),
		.out_entry  (out_entry),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp)
	);

	initial begin
		pcie_clk = 1'b0;
		forever #4 pcie_clk = ~pcie_clk;
	end

	task automatic check_entry(input string name, input capture_entry_t expected,
			input capture_entry_t actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("Mismatch %s: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_count(input string name, input count_t expected, input count_t actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("Mismatch %s: expected %0d actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] expected,
			input logic [1:0] actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("Mismatch %s: expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
		int   waited;
		logic aw_hit;
		logic w_hit;
		logic b_hit;
		waited           = 0;
		axil_req.awaddr  = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata   = data;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b1;
		while (axil_req.bready && waited < AXIL_TIMEOUT) begin
			aw_hit = axil_req.awvalid && axil_rsp.awready;
			w_hit  = axil_req.wvalid && axil_rsp.wready;
			b_hit  = axil_rsp.bvalid;
			// Write response must be OKAY
			if (b_hit)
				check_resp($sformatf("write %h BRESP", addr), 2'b00, axil_rsp.bresp);
			@(negedge pcie_clk);
			if (aw_hit)
				axil_req.awvalid = 1'b0;
			if (w_hit)
				axil_req.wvalid = 1'b0;
			if (b_hit)
				axil_req.bready = 1'b0;
			waited++;
		end
		if (axil_req.bready) begin
			failures++;
			$display("Register write to address %h got no response", addr);
			axil_req = '0;
		end
	endtask

	task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
		int   waited;
		logic ar_hit;
		logic r_hit;
		waited           = 0;
		data             = '0;
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b1;
		while (axil_req.rready && waited < AXIL_TIMEOUT) begin
			ar_hit = axil_req.arvalid && axil_rsp.arready;
			r_hit  = axil_rsp.rvalid;
			if (r_hit) begin
				data = axil_rsp.rdata;
				check_resp($sformatf("read %h RRESP", addr), 2'b00, axil_rsp.rresp);
			end
			@(negedge pcie_clk);
			if (ar_hit)
				axil_req.arvalid = 1'b0;
			if (r_hit)
				axil_req.rready = 1'b0;
			waited++;
		end
		if (axil_req.rready) begin
			failures++;
			$display("Register read from address %h got no response", addr);
			axil_req = '0;
		end
	endtask

	task automatic check_reg(input string name, input logic [31:0] addr, input count_t expected);
		logic [31:0] value;
		read_reg(addr, value);
		check_count(name, expected, value);
	endtask

	function automatic logic [31:0] header_dw0(input logic [2:0] fmt, input logic [4:0] typ,
			input dw_len_t len);
		return {fmt, typ, 14'h0000, len};
	endfunction

	// Requester ID, tag, byte enables
	function automatic logic [31:0] request_dw1(input tlp_tag_t tag);
		return {16'h0100, tag, 8'hFF};
	endfunction

	function automatic capture_entry_t terminator_entry();
		capture_entry_t e;
		e       = '0;
		e.tlast = 1'b1;
		e.err   = 1'b1;
		return e;
	endfunction

	task automatic clear_queues();
		tx_beats.delete();
		exp_entries.delete();
	endtask

	task automatic add_beat(input tdata_t data, input tkeep_t keep, input logic last);
		rx_beat_t b;
		b.tvalid = 1'b1;
		b.tlast  = last;
		b.tkeep  = keep;
		b.tdata  = data;
		b.tuser  = tuser_t'($urandom());
		tx_beats.push_back(b);
	endtask

	// Only the first entry of a packet carries length and tag
	task automatic expect_beats(input int first, input int n, input tlp_len_t len,
			input tlp_tag_t tag);
		capture_entry_t e;
		for (int i = first; i < first + n; i++) begin
			e.tlp_len = (i == first) ? len : '0;
			e.tlp_tag = (i == first) ? tag : '0;
			e.err     = 1'b0;
			e.tlast   = tx_beats[i].tlast;
			e.tkeep   = tx_beats[i].tkeep;
			e.tdata   = tx_beats[i].tdata;
			e.tuser   = tx_beats[i].tuser;
			exp_entries.push_back(e);
		end
	endtask

	task automatic send_packet();
		foreach (tx_beats[i]) begin
			rx = tx_beats[i];
			@(negedge pcie_clk);
		end
		rx = '0;
	endtask

	task automatic pop_entry(input int max_cycles, output capture_entry_t got, output logic ok);
		int waited;
		waited = 0;
		ok     = 1'b0;
		got    = '0;
		while (!out_valid && waited < max_cycles) begin
			@(negedge pcie_clk);
			waited++;
		end
		if (out_valid) begin
			got       = out_entry;
			ok        = 1'b1;
			out_ready = 1'b1;
			@(negedge pcie_clk);
			out_ready = 1'b0;
		end
	endtask

	task automatic verify_stream(input string name);
		capture_entry_t got;
		logic           ok;
		logic           lost;
		lost = 1'b0;
		for (int i = 0; i < exp_entries.size() && !lost; i++) begin
			pop_entry(POP_TIMEOUT, got, ok);
			if (!ok) begin
				lost = 1'b1;
				failures++;
				$display("%s: entry %0d of %0d never reached the output", name, i,
					exp_entries.size());
			end else begin
				check_entry($sformatf("%s entry %0d", name, i), exp_entries[i], got);
			end
		end
		pop_entry(10, got, ok);
		if (ok) begin
			failures++;
			$display("%s: unexpected extra entry %h", name, got);
		end
	endtask

	task automatic test_registers();
		check_reg("regs CTRL", `NETTLP_REG_CTRL, 1);
		check_reg("regs TIMEOUT", `NETTLP_REG_TIMEOUT, `NETTLP_TIMEOUT_DEFAULT);
		check_reg("regs TLP_CNT", `NETTLP_REG_TLP_CNT, 0);
		check_reg("regs DROP_CNT", `NETTLP_REG_DROP_CNT, 0);
		check_reg("regs TMO_CNT", `NETTLP_REG_TMO_CNT, 0);
		check_reg("regs OVF_CNT", `NETTLP_REG_OVF_CNT, 0);
		write_reg(`NETTLP_REG_TIMEOUT, 341);
		check_reg("regs TIMEOUT readback", `NETTLP_REG_TIMEOUT, 341);
		write_reg(`NETTLP_REG_TIMEOUT, `NETTLP_TIMEOUT_DEFAULT);
	endtask

	task automatic test_mem_write();
		clear_queues();
		add_beat({request_dw1(8'h5A), header_dw0(3'b010, 5'b00000, 10'd4)}, 8'hFF, 1'b0);
		add_beat({$urandom(), 32'h1000_0040}, 8'hFF, 1'b0);
		add_beat({$urandom(), $urandom()}, 8'hFF, 1'b1);
		expect_beats(0, 3, 11'd28, 8'h5A);
		send_packet();
		verify_stream("mwr_3dw");
		exp_tlp++;
		check_reg("mwr_3dw TLP_CNT", `NETTLP_REG_TLP_CNT, exp_tlp);
	endtask

	task automatic test_read_completion();
		clear_queues();
		add_beat({request_dw1(8'h21), header_dw0(3'b001, 5'b00000, 10'd1)}, 8'hFF, 1'b0);
		add_beat({32'h2000_0080, 32'h0000_0001}, 8'hFF, 1'b1);
		expect_beats(0, 2, 11'd16, 8'h21);
		send_packet();
		verify_stream("mrd_4dw");
		exp_tlp++;
		// Completion tag sits in DW2 of the second beat
		clear_queues();
		add_beat({32'h0200_0004, header_dw0(3'b010, 5'b01010, 10'd1)}, 8'hFF, 1'b0);
		add_beat({$urandom(), 16'h0100, 8'h37, 8'h00}, 8'hFF, 1'b1);
		expect_beats(0, 2, 11'd16, 8'h37);
		send_packet();
		verify_stream("cpl_data");
		exp_tlp++;
		check_reg("mrd_cpl TLP_CNT", `NETTLP_REG_TLP_CNT, exp_tlp);
	endtask

	task automatic test_unsupported_drop();
		clear_queues();
		add_beat({request_dw1(8'h90), header_dw0(3'b010, 5'b00100, 10'd1)}, 8'hFF, 1'b0);
		add_beat({$urandom(), 32'h0100_0010}, 8'hFF, 1'b1);
		add_beat({request_dw1(8'h44), header_dw0(3'b000, 5'b00000, 10'd1)}, 8'hFF, 1'b0);
		add_beat({32'h0, 32'h3000_0100}, 8'h0F, 1'b1);
		expect_beats(2, 2, 11'd12, 8'h44);
		send_packet();
		verify_stream("drop_then_mrd");
		exp_drop++;
		exp_tlp++;
		check_reg("drop DROP_CNT", `NETTLP_REG_DROP_CNT, exp_drop);
		check_reg("drop TLP_CNT", `NETTLP_REG_TLP_CNT, exp_tlp);
	endtask

	task automatic test_fifo_overflow();
		int n_beats;
		int dw;
		n_beats = `NETTLP_FIFO_DEPTH + 16;
		dw      = (n_beats * 8 - 12) / 4;
		clear_queues();
		add_beat({request_dw1(8'h66), header_dw0(3'b010, 5'b00000, dw_len_t'(dw))},
			8'hFF, 1'b0);
		for (int i = 1; i < n_beats; i++)
			add_beat({$urandom(), $urandom()}, 8'hFF, i == n_beats - 1);
		// Only a full FIFO worth of beats survives
		expect_beats(0, `NETTLP_FIFO_DEPTH, tlp_len_t'(4 * dw + 12), 8'h66);
		exp_entries.push_back(terminator_entry());
		send_packet();
		verify_stream("overflow");
		exp_ovf++;
		check_reg("overflow OVF_CNT", `NETTLP_REG_OVF_CNT, exp_ovf);
		check_reg("overflow TLP_CNT", `NETTLP_REG_TLP_CNT, exp_tlp);
	endtask

	task automatic test_stall_timeout();
		write_reg(`NETTLP_REG_TIMEOUT, 20);
		clear_queues();
		add_beat({request_dw1(8'h77), header_dw0(3'b011, 5'b00000, 10'd8)}, 8'hFF, 1'b0);
		add_beat({32'h4000_0000, 32'h0000_0002}, 8'hFF, 1'b0);
		expect_beats(0, 2, 11'd48, 8'h77);
		exp_entries.push_back(terminator_entry());
		send_packet();
		verify_stream("timeout");
		exp_tmo++;
		check_reg("timeout TMO_CNT", `NETTLP_REG_TMO_CNT, exp_tmo);
	endtask

	initial begin
		void'($urandom(6));
		pcie_rst    = 1'b1;
		pcie_tready = 1'b1;
		rx          = '0;
		out_ready   = 1'b0;
		axil_req    = '0;
		exp_tlp     = '0;
		exp_drop    = '0;
		exp_tmo     = '0;
		exp_ovf     = '0;
		checks      = 0;
		mismatches  = 0;
		failures    = 0;
		repeat (4) @(negedge pcie_clk);
		pcie_rst = 1'b0;
		@(negedge pcie_clk);

		test_registers();
		test_mem_write();
		test_read_completion();
		test_unsupported_drop();
		test_fifo_overflow();
		test_stall_timeout();

		@(negedge pcie_clk);
		$display("Summary: %0d checks, %0d mismatches, %0d other errors",
			checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: verilog/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo #(
	parameter int DEPTH = 64
) (
	input  logic                       pcie_clk,
	input  logic                       pcie_rst,
	input  logic                       wr_en,
	input  nettlp_pkg::capture_entry_t din,
	output logic                       full,
	output nettlp_pkg::capture_entry_t out_entry,
	output logic                       out_valid,
	input  logic                       out_ready
);
	import nettlp_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	capture_entry_t mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [CW-1:0]  count;
	logic           do_wr;
	logic           do_rd;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full      = (count == CW'(DEPTH));
	assign out_valid = (count != '0);
	assign out_entry = mem[rd_ptr];
	assign do_wr     = wr_en && !full;
	assign do_rd     = out_valid && out_ready;

	always_ff @(posedge pcie_clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_rd)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous read and write leave the count alone
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overrun: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
		wr_en |-> !full)
		else $error("FIFO written while full");

endmodule

// File: verilog/capture_regs.sv
`timescale 1ns/1ps
`include "nettlp_config.svh"

module capture_regs (
	input  logic                        pcie_clk,
	input  logic                        pcie_rst,
	input  nettlp_pkg::axil_req_t       axil_req,
	output nettlp_pkg::axil_rsp_t       axil_rsp,
	input  nettlp_pkg::capture_events_t events,
	output logic                        enable,
	output nettlp_pkg::timeout_t        timeout_limit
);
	import nettlp_pkg::*;

	logic        awready, wready, bvalid;
	logic        arready, rvalid;
	logic        aw_seen, w_seen;
	logic [31:0] aw_addr, w_data;
	logic [31:0] rdata, rd_value;
	logic        do_write, clear;
	count_t      tlp_cnt, drop_cnt, tmo_cnt, ovf_cnt;

	function automatic count_t sat_inc(input count_t value, input logic hit);
		return (hit && value != '1) ? value + 1'b1 : value;
	endfunction

	assign do_write = aw_seen && w_seen && !bvalid;
	assign clear    = do_write && (aw_addr == `NETTLP_REG_CTRL) && w_data[1];

	// AW and W are accepted independently
	always_ff @(posedge pcie_clk) begin
		if (pcie_rst) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			aw_seen <= 1'b0;
			w_seen  <= 1'b0;
		end else begin
			awready <= axil_req.awvalid && !awready && !aw_seen;
			wready  <= axil_req.wvalid && !wready && !w_seen;
			if (axil_req.awvalid && awready)
				aw_seen <= 1'b1;
			if (axil_req.wvalid && wready)
				w_seen <= 1'b1;
			if (do_write) begin
				aw_seen <= 1'b0;
				w_seen  <= 1'b0;
				bvalid  <= 1'b1;
			end else if (bvalid && axil_req.bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (axil_req.awvalid && awready)
			aw_addr <= axil_req.awaddr;
		if (axil_req.wvalid && wready)
			w_data <= axil_req.wdata;
	end

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst) begin
			enable        <= 1'b1;
			timeout_limit <= timeout_t'(`NETTLP_TIMEOUT_DEFAULT);
		end else if (do_write) begin
			if (aw_addr == `NETTLP_REG_CTRL)
				enable <= w_data[0];
			if (aw_addr == `NETTLP_REG_TIMEOUT)
				timeout_limit <= w_data[$bits(timeout_t)-1:0];
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst || clear) begin
			tlp_cnt  <= '0;
			drop_cnt <= '0;
			tmo_cnt  <= '0;
			ovf_cnt  <= '0;
		end else begin
			tlp_cnt  <= sat_inc(tlp_cnt, events.tlp_done);
			drop_cnt <= sat_inc(drop_cnt, events.dropped);
			tmo_cnt  <= sat_inc(tmo_cnt, events.timed_out);
			ovf_cnt  <= sat_inc(ovf_cnt, events.overflowed);
		end
	end

	always_comb begin
		case (axil_req.araddr)
			`NETTLP_REG_CTRL:     rd_value = {31'b0, enable};
			`NETTLP_REG_TIMEOUT:  rd_value = 32'(timeout_limit);
			`NETTLP_REG_TLP_CNT:  rd_value = tlp_cnt;
			`NETTLP_REG_DROP_CNT: rd_value = drop_cnt;
			`NETTLP_REG_TMO_CNT:  rd_value = tmo_cnt;
			`NETTLP_REG_OVF_CNT:  rd_value = ovf_cnt;
			default:              rd_value = '0;
		endcase
	end

	// Read data is held until the master takes it
	always_ff @(posedge pcie_clk) begin
		if (pcie_rst) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= axil_req.arvalid && !arready && !rvalid;
			if (axil_req.arvalid && arready)
				rvalid <= 1'b1;
			else if (rvalid && axil_req.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge pcie_clk) begin
		if (axil_req.arvalid && arready)
			rdata <= rd_value;
	end

	always_comb begin
		axil_rsp.awready = awready;
		axil_rsp.wready  = wready;
		axil_rsp.bvalid  = bvalid;
		axil_rsp.bresp   = 2'b00;
		axil_rsp.arready = arready;
		axil_rsp.rvalid  = rvalid;
		axil_rsp.rdata   = rdata;
		axil_rsp.rresp   = 2'b00;
	end

endmodule

// File: verilog/capture_timer.sv
`timescale 1ns/1ps

module capture_timer (
	input  logic                 pcie_clk,
	input  logic                 pcie_rst,
	input  logic                 run,
	input  nettlp_pkg::timeout_t limit,
	output logic                 expired
);
	import nettlp_pkg::*;

	timeout_t count;

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst || !run)
			count <= '0;
		else if (count > limit)
			count <= limit;  // limit lowered mid-packet
		else if (count != limit)
			count <= count + 1'b1;
	end

	assign expired = run && (count == limit);

	a_count_bounded: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
		run && $stable(limit) |-> count <= limit)
		else $error("timeout count passed its limit");

endmodule

// File: verilog/nettlp_config.svh
`ifndef NETTLP_CONFIG_SVH
`define NETTLP_CONFIG_SVH

// PCIe receive stream width
`define NETTLP_DATA_WIDTH 64

// Capture FIFO entries
`define NETTLP_FIFO_DEPTH 64

// Cycles before an open packet is closed
`define NETTLP_TIMEOUT_DEFAULT 500

// Register map, byte addresses
`define NETTLP_REG_CTRL     32'h0000_0000
`define NETTLP_REG_TIMEOUT  32'h0000_0004
`define NETTLP_REG_TLP_CNT  32'h0000_0008
`define NETTLP_REG_DROP_CNT 32'h0000_000C
`define NETTLP_REG_TMO_CNT  32'h0000_0010
`define NETTLP_REG_OVF_CNT  32'h0000_0014

`endif

// File: verilog/nettlp_pkg.sv
`include "nettlp_config.svh"

package nettlp_pkg;

	typedef logic [`NETTLP_DATA_WIDTH-1:0]   tdata_t;
	typedef logic [`NETTLP_DATA_WIDTH/8-1:0] tkeep_t;
	typedef logic [21:0] tuser_t;
	typedef logic [10:0] tlp_len_t;
	typedef logic [7:0]  tlp_tag_t;
	typedef logic [9:0]  dw_len_t;
	typedef logic [9:0]  timeout_t;
	typedef logic [31:0] count_t;

	// One code per supported fmt/type pair
	typedef enum logic [2:0] {
		MRD_3DW_NODATA,
		MRD_4DW_NODATA,
		MWR_3DW_DATA,
		MWR_4DW_DATA,
		CPL_NODATA,
		CPL_DATA
	} tlp_fmt_e;

	typedef enum logic [4:0] {
		MEMRW = 5'b00000,
		COMPL = 5'b01010
	} tlp_type_e;

	typedef struct packed {
		logic   tvalid;
		logic   tlast;
		tkeep_t tkeep;
		tdata_t tdata;
		tuser_t tuser;
	} rx_beat_t;

	// tlp_len and tlp_tag are only set on the first beat
	typedef struct packed {
		tlp_len_t tlp_len;
		tlp_tag_t tlp_tag;
		logic     err;
		logic     tlast;
		tkeep_t   tkeep;
		tdata_t   tdata;
		tuser_t   tuser;
	} capture_entry_t;

	typedef struct packed {
		logic tlp_done;
		logic dropped;
		logic timed_out;
		logic overflowed;
	} capture_events_t;

	typedef struct packed {
		logic [31:0] awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic        wvalid;
		logic        bready;
		logic [31:0] araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

endpackage

// File: verilog/nettlp_rx_capture.sv
`timescale 1ns/1ps
`include "nettlp_config.svh"

module nettlp_rx_capture (
	input  logic                       pcie_clk,
	input  logic                       pcie_rst,
	input  logic                       pcie_tready,
	input  nettlp_pkg::rx_beat_t       rx,
	output nettlp_pkg::capture_entry_t out_entry,
	output logic                       out_valid,
	input  logic                       out_ready,
	input  nettlp_pkg::axil_req_t      axil_req,
	output nettlp_pkg::axil_rsp_t      axil_rsp
);
	import nettlp_pkg::*;

	logic            enable;
	logic            full;
	logic            expired;
	logic            run;
	logic            wr_en;
	capture_entry_t  entry;
	capture_events_t events;
	timeout_t        timeout_limit;

	tlp_capture_fsm tlp_capture_fsm_i (
		.pcie_clk   (pcie_clk),
		.pcie_rst   (pcie_rst),
		.pcie_tready(pcie_tready),
		.rx         (rx),
		.enable     (enable),
		.full       (full),
		.expired    (expired),
		.run        (run),
		.wr_en      (wr_en),
		.entry      (entry),
		.events     (events)
	);

	capture_timer capture_timer_i (
		.pcie_clk(pcie_clk),
		.pcie_rst(pcie_rst),
		.run     (run),
		.limit   (timeout_limit),
		.expired (expired)
	);

	beat_fifo #(
		.DEPTH(`NETTLP_FIFO_DEPTH)
	) beat_fifo_i (
		.pcie_clk (pcie_clk),
		.pcie_rst (pcie_rst),
		.wr_en    (wr_en),
		.din      (entry),
		.full     (full),
		.out_entry(out_entry),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	capture_regs capture_regs_i (
		.pcie_clk     (pcie_clk),
		.pcie_rst     (pcie_rst),
		.axil_req     (axil_req),
		.axil_rsp     (axil_rsp),
		.events       (events),
		.enable       (enable),
		.timeout_limit(timeout_limit)
	);

endmodule

// File: verilog/tlp_capture_fsm.sv
`timescale 1ns/1ps

module tlp_capture_fsm (
	input  logic                        pcie_clk,
	input  logic                        pcie_rst,
	input  logic                        pcie_tready,
	input  nettlp_pkg::rx_beat_t        rx,
	input  logic                        enable,
	input  logic                        full,
	input  logic                        expired,
	output logic                        run,
	output logic                        wr_en,
	output nettlp_pkg::capture_entry_t  entry,
	output nettlp_pkg::capture_events_t events
);
	import nettlp_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		HEADER,
		DATA,
		DROP,
		ERR_TIMEOUT,
		ERR_FIFOFULL
	} state_e;

	localparam capture_entry_t TERMINATOR = '{tlast: 1'b1, err: 1'b1, default: '0};

	state_e   state;
	state_e   state_next;
	logic     tready_q;
	rx_beat_t rx_q;
	logic     beat_ok;
	logic     supported;
	tlp_len_t hdr_len;
	tlp_tag_t hdr_tag;
	logic     lost_last;

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst) begin
			tready_q <= 1'b0;
			rx_q     <= '0;
		end else begin
			tready_q <= pcie_tready;
			rx_q     <= rx;
		end
	end

	assign beat_ok = tready_q && rx_q.tvalid;

	// Next beat still unregistered here, it carries the completion tag
	tlp_header_decode tlp_header_decode_i (
		.first_beat(rx_q),
		.next_beat (rx),
		.supported (supported),
		.tlp_len   (hdr_len),
		.tlp_tag   (hdr_tag)
	);

	always_ff @(posedge pcie_clk) begin
		if (pcie_rst)
			state <= IDLE;
		else
			state <= state_next;
	end

	// Remembers whether the packet end was already lost while full
	always_ff @(posedge pcie_clk) begin
		if (pcie_rst)
			lost_last <= 1'b0;
		else if (state != ERR_FIFOFULL)
			lost_last <= beat_ok && rx_q.tlast;
		else if (beat_ok && rx_q.tlast)
			lost_last <= 1'b1;
	end

	assign run = (state == HEADER) || (state == DATA);

	always_comb begin
		state_next    = state;
		wr_en         = 1'b0;
		events        = '0;
		entry.tlp_len = '0;
		entry.tlp_tag = '0;
		entry.err     = 1'b0;
		entry.tlast   = rx_q.tlast;
		entry.tkeep   = rx_q.tkeep;
		entry.tdata   = rx_q.tdata;
		entry.tuser   = rx_q.tuser;

		case (state)
		IDLE: begin
			if (enable && beat_ok && !rx_q.tlast) begin
				if (supported && !full) begin
					state_next    = HEADER;
					wr_en         = 1'b1;
					entry.tlp_len = hdr_len;
					entry.tlp_tag = hdr_tag;
				end else begin
					state_next     = DROP;
					events.dropped = 1'b1;
				end
			end
		end
		HEADER, DATA: begin
			if (expired) begin
				state_next = ERR_TIMEOUT;
			end else if (beat_ok) begin
				if (full) begin
					state_next = ERR_FIFOFULL;
				end else begin
					wr_en = 1'b1;
					if (rx_q.tlast) begin
						state_next      = IDLE;
						events.tlp_done = 1'b1;
					end else begin
						state_next = DATA;
					end
				end
			end
		end
		DROP: begin
			if (beat_ok && rx_q.tlast)
				state_next = IDLE;
		end
		ERR_TIMEOUT: begin
			if (!full) begin
				state_next       = IDLE;
				wr_en            = 1'b1;
				entry            = TERMINATOR;
				events.timed_out = 1'b1;
			end
		end
		ERR_FIFOFULL: begin
			if (!full) begin
				wr_en             = 1'b1;
				entry             = TERMINATOR;
				events.overflowed = 1'b1;
				if (lost_last || (beat_ok && rx_q.tlast))
					state_next = IDLE;
				else
					state_next = DROP;
			end
		end
		default: begin
			state_next = IDLE;
		end
		endcase
	end

	a_no_write_full: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
		wr_en |-> !full)
		else $error("capture write while FIFO full");

	a_event_pulse: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
		events != '0 |=> (events & $past(events)) == '0)
		else $error("event held longer than one cycle");

endmodule

// File: verilog/tlp_header_decode.sv
`timescale 1ns/1ps

module tlp_header_decode (
	input  nettlp_pkg::rx_beat_t first_beat,
	input  nettlp_pkg::rx_beat_t next_beat,
	output logic                 supported,
	output nettlp_pkg::tlp_len_t tlp_len,
	output nettlp_pkg::tlp_tag_t tlp_tag
);
	import nettlp_pkg::*;

	logic [2:0] fmt;
	logic [4:0] pkt_type;
	dw_len_t    length;
	tlp_len_t   data_bytes;
	tlp_fmt_e   kind;

	// DW0 sits in the low half of the first beat
	assign fmt        = first_beat.tdata[31:29];
	assign pkt_type   = first_beat.tdata[28:24];
	assign length     = first_beat.tdata[9:0];
	assign data_bytes = {length[8:0], 2'b00};

	always_comb begin
		supported = 1'b1;
		kind      = MRD_3DW_NODATA;
		case ({fmt, pkt_type})
			{3'b000, MEMRW}: kind = MRD_3DW_NODATA;
			{3'b001, MEMRW}: kind = MRD_4DW_NODATA;
			{3'b010, MEMRW}: kind = MWR_3DW_DATA;
			{3'b011, MEMRW}: kind = MWR_4DW_DATA;
			{3'b000, COMPL}: kind = CPL_NODATA;
			{3'b010, COMPL}: kind = CPL_DATA;
			default:         supported = 1'b0;
		endcase
	end

	always_comb begin
		case (kind)
			MRD_3DW_NODATA, CPL_NODATA: tlp_len = 11'd12;
			MRD_4DW_NODATA:             tlp_len = 11'd16;
			MWR_3DW_DATA, CPL_DATA:     tlp_len = data_bytes + 11'd12;
			default:                    tlp_len = data_bytes + 11'd16;
		endcase
		// Completion tag lives in DW2, carried by the second beat
		if (kind == CPL_NODATA || kind == CPL_DATA)
			tlp_tag = next_beat.tdata[15:8];
		else
			tlp_tag = first_beat.tdata[47:40];
	end

endmodule
